// ==== Makefile ====
# Verilator build and run for the stereo mixer testbench

SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_mixer
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := All tests passed

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/tb_mixer.sv ====
////////////////////////////////////////////////////////////
// tb_mixer: reference model, result checker, directed and
// random tests for mixer_top
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_mixer;

  import mixer_pkg::*;

  localparam longint SAMPLE_MAX = (longint'(1) << (AUDIO_WIDTH - 1)) - 1;
  localparam longint SAMPLE_MIN = -SAMPLE_MAX - 1;
  localparam int     UNITY      = 1 << Q_BITS;
  localparam int     TIMEOUT    = 400;  // cycles per wait

  typedef struct packed {
    sample_t    left;
    sample_t    right;
    logic       out_clip;
    chan_mask_t channel_clip;
  } result_t;

  logic        clk;
  logic        rst_n;
  sample_t     sample;
  chan_idx_t   sample_chan;
  logic        sample_strobe;
  gain_array_t channel_gain;
  chan_mask_t  channel_pan;
  gain_t       output_gain;
  logic        status_clear;
  sample_t     out_left;
  sample_t     out_right;
  logic        out_valid;
  logic        out_ready;
  logic        out_clip;
  chan_mask_t  channel_clip;
  logic        overrun;

  logic [31:0] lcg_state = 32'h3cc4c57a;
  result_t     expected_q [$];
  frame_t      slots;               // what the capture side holds
  logic        exp_out_clip;
  chan_mask_t  exp_chan_clip;
  logic        exp_overrun;
  int          error_count = 0;
  int          test_errors = 0;
  int          tests_run   = 0;
  int          tests_bad   = 0;
  logic        ready_random = 1'b0;
  int          ready_span   = 0;
  logic        hold_pending = 1'b0;
  sample_t     held_left;
  sample_t     held_right;
  result_t     popped;

  mixer_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample        (sample),
    .sample_chan   (sample_chan),
    .sample_strobe (sample_strobe),
    .channel_gain  (channel_gain),
    .channel_pan   (channel_pan),
    .output_gain   (output_gain),
    .status_clear  (status_clear),
    .out_left      (out_left),
    .out_right     (out_right),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_clip      (out_clip),
    .channel_clip  (channel_clip),
    .overrun       (overrun)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic longint clamp(input longint v);
    if (v > SAMPLE_MAX) return SAMPLE_MAX;
    if (v < SAMPLE_MIN) return SAMPLE_MIN;
    return v;
  endfunction

  function automatic result_t mix_reference(input frame_t f, input gain_array_t g,
                                            input chan_mask_t pan, input gain_t master);
    result_t r;
    sample_t s;
    gain_t   k;
    longint  prod;
    longint  bus [2];
    longint  scaled;
    r      = '0;
    bus[0] = 0;
    bus[1] = 0;
    for (int i = 0; i < NR_CHANNELS; i++) begin
      s    = f[i];
      k    = g[i];
      prod = (longint'(s) * longint'(k)) >>> Q_BITS;  // floor
      r.channel_clip[i] = (clamp(prod) != prod);
      bus[pan[i]] += clamp(prod);                     // index 0 is left
    end
    for (int b = 0; b < 2; b++) begin
      if (clamp(bus[b]) != bus[b]) r.out_clip = 1'b1;
      scaled = (clamp(bus[b]) * longint'(master)) >>> Q_BITS;
      if (clamp(scaled) != scaled) r.out_clip = 1'b1;
      if (b == 0) r.left = sample_t'(clamp(scaled));
      else r.right = sample_t'(clamp(scaled));
    end
    return r;
  endfunction

  function automatic frame_t make_frame(input int s0, input int s1, input int s2,
                                        input int s3);
    frame_t f;
    f[0] = sample_t'(s0);
    f[1] = sample_t'(s1);
    f[2] = sample_t'(s2);
    f[3] = sample_t'(s3);
    return f;
  endfunction

  function automatic frame_t random_frame();
    frame_t      f;
    logic [31:0] r;
    for (int i = 0; i < NR_CHANNELS; i++) begin
      r    = next_random();
      f[i] = sample_t'(r[31:16]);
    end
    return f;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic send_sample(input chan_idx_t ch, input sample_t s);
    result_t r;
    @(negedge clk);
    sample        = s;
    sample_chan   = ch;
    sample_strobe = 1'b1;
    slots[ch]     = s;
    if (ch == chan_idx_t'(NR_CHANNELS - 1)) begin  // last index closes a frame
      r = mix_reference(slots, channel_gain, channel_pan, output_gain);
      expected_q.push_back(r);
      exp_out_clip  = exp_out_clip | r.out_clip;
      exp_chan_clip = exp_chan_clip | r.channel_clip;
    end
  endtask

  task automatic send_frame(input frame_t f, input logic shuffle);
    chan_idx_t   order [NR_CHANNELS];
    chan_idx_t   tmp;
    int          j;
    logic [31:0] r;
    for (int i = 0; i < NR_CHANNELS; i++) order[i] = chan_idx_t'(i);
    if (shuffle) begin
      for (int i = NR_CHANNELS - 1; i > 0; i--) begin
        r        = next_random();
        j        = int'(r[31:16]) % (i + 1);
        tmp      = order[i];
        order[i] = order[j];
        order[j] = tmp;
      end
    end
    for (int i = 0; i < NR_CHANNELS; i++) send_sample(order[i], f[order[i]]);
    @(negedge clk);
    sample_strobe = 1'b0;
  endtask

  // waits until every expected result has been taken
  task automatic wait_drain(input int limit);
    int          cycles;
    logic [31:0] r;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (ready_random) begin
        if (ready_span == 0) begin
          r          = next_random();
          out_ready  = r[20];
          ready_span = int'(r[27:24]) + 1;  // hold the level a while
        end
        ready_span--;
      end
    end
    if (expected_q.size() != 0) begin
      $display("Hang: %0d results never arrived within %0d cycles", expected_q.size(), cycles);
      $display("Some tests failed");
      $finish;
    end
  endtask

  task automatic clear_status();
    @(negedge clk);
    status_clear = 1'b1;
    @(negedge clk);
    status_clear  = 1'b0;
    exp_out_clip  = 1'b0;
    exp_chan_clip = '0;
    exp_overrun   = 1'b0;
  endtask

  task automatic check_status();
    @(negedge clk);
    if (out_clip !== exp_out_clip) begin
      $display("Error at %0t: out_clip %b, expected %b", $time, out_clip, exp_out_clip);
      error_count++;
    end
    if (channel_clip !== exp_chan_clip) begin
      $display("Error at %0t: channel_clip %b, expected %b", $time, channel_clip,
               exp_chan_clip);
      error_count++;
    end
    if (overrun !== exp_overrun) begin
      $display("Error at %0t: overrun %b, expected %b", $time, overrun, exp_overrun);
      error_count++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (error_count == test_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", name, error_count - test_errors);
    end
    test_errors = error_count;
  endtask

  task automatic set_unity();
    for (int i = 0; i < NR_CHANNELS; i++) channel_gain[i] = gain_t'(UNITY);
    output_gain = gain_t'(UNITY);
  endtask

  ////////////////////////////////////////////////////////////
  // checker, sampled before the edge updates the DUT
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n && hold_pending) begin
      if (!out_valid || out_left !== held_left || out_right !== held_right) begin
        $display("Error at %0t: output changed while out_ready was low", $time);
        error_count++;
      end
    end
    hold_pending = rst_n && out_valid && !out_ready;
    held_left    = out_left;
    held_right   = out_right;
    if (rst_n && out_valid && out_ready) begin
      if (expected_q.size() == 0) begin
        $display("Error at %0t: result %0d/%0d with none expected", $time, out_left,
                 out_right);
        error_count++;
      end else begin
        popped = expected_q.pop_front();
        if (out_left !== popped.left) begin
          $display("Error at %0t: left %0d, expected %0d", $time, out_left, popped.left);
          error_count++;
        end
        if (out_right !== popped.right) begin
          $display("Error at %0t: right %0d, expected %0d", $time, out_right, popped.right);
          error_count++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          cycles;
    logic [31:0] r;
    rst_n         = 1'b0;
    sample        = '0;
    sample_chan   = '0;
    sample_strobe = 1'b0;
    channel_pan   = '0;
    status_clear  = 1'b0;
    out_ready     = 1'b1;
    exp_out_clip  = 1'b0;
    exp_chan_clip = '0;
    exp_overrun   = 1'b0;
    set_unity();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // unity gains, alternating pan, latency of the first frame
    channel_pan = 4'b1010;
    send_frame(make_frame(1000, -2000, 3000, 400), 1'b0);
    cycles = 1;
    while (!out_valid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!out_valid) begin
      $display("Hang: out_valid never rose after the first frame");
      $display("Some tests failed");
      $finish;
    end
    if (cycles != 5) begin
      $display("Error at %0t: out_valid after %0d cycles, expected 5", $time, cycles);
      error_count++;
    end
    wait_drain(TIMEOUT);
    channel_pan = 4'b0101;
    send_frame(make_frame(30000, 5, 30000, -7), 1'b0);  // right bus saturates
    wait_drain(TIMEOUT);
    send_frame(make_frame(-20000, -30000, -20000, -10000), 1'b0);
    wait_drain(TIMEOUT);
    check_status();
    end_test("unity routing");

    // random samples, gains and pan, shuffled channel order
    clear_status();
    for (int n = 0; n < 200; n++) begin
      for (int i = 0; i < NR_CHANNELS; i++) begin
        r               = next_random();
        channel_gain[i] = gain_t'($signed(r[29:16]));  // about +-2x
      end
      r           = next_random();
      channel_pan = r[19:16];
      output_gain = gain_t'($signed(r[29:17]));
      send_frame(random_frame(), 1'b1);
      wait_drain(TIMEOUT);
    end
    check_status();
    end_test("random mix");

    // channel, bus and master saturation on both polarities
    clear_status();
    set_unity();
    channel_gain[0] = gain_t'(2 * UNITY);
    output_gain     = gain_t'(2 * UNITY);
    channel_pan     = 4'b1010;
    send_frame(make_frame(20000, 12000, 20000, 12000), 1'b0);
    wait_drain(TIMEOUT);
    send_frame(make_frame(-20000, -12000, -20000, -12000), 1'b0);
    wait_drain(TIMEOUT);
    check_status();
    clear_status();
    check_status();
    end_test("clipping");

    // random out_ready spans with spaced single frames
    set_unity();
    output_gain  = gain_t'(UNITY / 2);
    r            = next_random();
    channel_pan  = r[23:20];
    ready_random = 1'b1;
    ready_span   = 0;
    for (int n = 0; n < 40; n++) begin
      send_frame(random_frame(), 1'b0);
      wait_drain(TIMEOUT);
      r = next_random();
      repeat (int'(r[22:20])) @(negedge clk);
    end
    ready_random = 1'b0;
    out_ready    = 1'b1;
    check_status();
    end_test("back-pressure hold");

    // two frames back to back into a stalled output
    clear_status();
    set_unity();
    channel_pan = 4'b1010;
    out_ready   = 1'b0;
    for (int i = 0; i < NR_CHANNELS; i++) send_sample(chan_idx_t'(i), sample_t'(100 * (i + 1)));
    for (int i = 0; i < NR_CHANNELS; i++) send_sample(chan_idx_t'(i), sample_t'(-50 * (i + 1)));
    @(negedge clk);
    sample_strobe = 1'b0;
    void'(expected_q.pop_back());  // holding register is still full
    exp_overrun = 1'b1;
    cycles      = 0;
    while (!overrun && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!overrun) begin
      $display("Hang: overrun never set while the output was stalled");
      $display("Some tests failed");
      $finish;
    end
    if (!out_valid) begin
      $display("Error at %0t: first result not held while stalled", $time);
      error_count++;
    end
    out_ready = 1'b1;
    wait_drain(TIMEOUT);
    repeat (8) @(negedge clk);  // a second result would show up here
    check_status();
    clear_status();
    check_status();
    end_test("overrun");

    $display("%0d tests run, %0d with errors, %0d errors in total", tests_run, tests_bad,
             error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/mixer_pkg.sv
verilog/mix_result_if.sv
verilog/channel_capture.sv
verilog/nq_multiplier.sv
verilog/mixer_core.sv
verilog/mixer_output.sv
verilog/mixer_top.sv
dv/tb_mixer.sv

// ==== verilog/channel_capture.sv ====
////////////////////////////////////////////////////////////
// channel_capture: strobed per-channel samples into a frame,
// frame valid pulse on the last channel index
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module channel_capture (
  input  logic                 clk,
  input  logic                 rst_n,

  input  mixer_pkg::sample_t   sample,
  input  mixer_pkg::chan_idx_t sample_chan,
  input  logic                 sample_strobe,

  output mixer_pkg::frame_t    frame,
  output logic                 frame_valid
);

  import mixer_pkg::*;

  chan_mask_t slot_we;    // one write enable per slot
  logic       last_chan;

  ////////////////////////////////////////////////////////////
  // slot decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    slot_we = '0;
    if (sample_strobe) begin
      slot_we[sample_chan] = 1'b1;
    end
  end

  assign last_chan = (sample_chan == chan_idx_t'(NR_CHANNELS - 1));

  ////////////////////////////////////////////////////////////
  // frame storage
  ////////////////////////////////////////////////////////////

  // slots not written keep their old sample
  always_ff @(posedge clk) begin
    for (int i = 0; i < NR_CHANNELS; i++) begin
      if (slot_we[i]) begin
        frame[i] <= sample;
      end
    end
  end

  // order of arrival does not matter, only the last index closes a frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= sample_strobe && last_chan;  // aligned with last write
    end
  end

endmodule

// ==== verilog/mix_result_if.sv ====
////////////////////////////////////////////////////////////
// mix_result_if: stereo result with clip flags, core to
// output side
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface mix_result_if;

  import mixer_pkg::*;

  sample_t    left;
  sample_t    right;
  logic       valid;         // one cycle per result
  logic       out_clip;      // bus or master saturation
  chan_mask_t channel_clip;  // channel gain saturation

  // producer side
  modport core (
    output left, right, valid, out_clip, channel_clip
  );

  // consumer side
  modport sink (
    input left, right, valid, out_clip, channel_clip
  );

endinterface

// ==== verilog/mixer_core.sv ====
////////////////////////////////////////////////////////////
// mixer_core: channel gains, pan routing, saturating bus
// sums and master gain, three stage pipeline
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mixer_core (
  input  logic                   clk,
  input  logic                   rst_n,

  input  mixer_pkg::frame_t      frame,
  input  logic                   frame_valid,

  input  mixer_pkg::gain_array_t channel_gain,
  input  mixer_pkg::chan_mask_t  channel_pan,
  input  mixer_pkg::gain_t       output_gain,

  mix_result_if.core             result
);

  import mixer_pkg::*;

  logic [2:0] valid_d;                    // one bit per stage

  sample_t    chan_prod [NR_CHANNELS];
  chan_mask_t chan_ovf;
  chan_mask_t chan_clip_d1;
  chan_mask_t chan_clip_d2;

  logic signed [SUM_WIDTH-1:0] left_acc;
  logic signed [SUM_WIDTH-1:0] right_acc;
  sample_t left_sat;
  sample_t right_sat;
  logic    left_bus_clip;
  logic    right_bus_clip;
  sample_t left_sum_q;
  sample_t right_sum_q;
  logic    bus_clip_q;
  logic    bus_clip_d;

  sample_t left_out;
  sample_t right_out;
  logic    left_master_ovf;
  logic    right_master_ovf;

  // clamp a bus sum into the sample range
  function automatic sample_t sat_sum(input logic signed [SUM_WIDTH-1:0] sum);
    logic upper_ok;
    upper_ok = (&sum[SUM_WIDTH-1:AUDIO_WIDTH-1]) || !(|sum[SUM_WIDTH-1:AUDIO_WIDTH-1]);
    if (upper_ok) begin
      return sum[AUDIO_WIDTH-1:0];
    end
    return sum[SUM_WIDTH-1] ? {1'b1, {(AUDIO_WIDTH-1){1'b0}}}
                            : {1'b0, {(AUDIO_WIDTH-1){1'b1}}};
  endfunction

  ////////////////////////////////////////////////////////////
  // stage 1: channel gain
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NR_CHANNELS; i++) begin : g_chan
    nq_multiplier #(
      .N_BITS (AUDIO_WIDTH),
      .Q_BITS (Q_BITS)
    ) chan_mul (
      .clk          (clk),
      .rst_n        (rst_n),
      .multiplicand (frame[i]),
      .multiplier   (channel_gain[i]),
      .product      (chan_prod[i]),
      .overflow     (chan_ovf[i])
    );
  end

  ////////////////////////////////////////////////////////////
  // stage 2: pan routing and bus sums
  ////////////////////////////////////////////////////////////

  always_comb begin
    left_acc  = '0;
    right_acc = '0;
    for (int i = 0; i < NR_CHANNELS; i++) begin
      if (!channel_pan[i]) begin
        left_acc  = left_acc + SUM_WIDTH'(chan_prod[i]);   // pan clear goes left
      end else begin
        right_acc = right_acc + SUM_WIDTH'(chan_prod[i]);
      end
    end
  end

  assign left_sat       = sat_sum(left_acc);
  assign right_sat      = sat_sum(right_acc);
  assign left_bus_clip  = (SUM_WIDTH'(left_sat) != left_acc);
  assign right_bus_clip = (SUM_WIDTH'(right_sat) != right_acc);

  always_ff @(posedge clk) begin
    left_sum_q  <= left_sat;
    right_sum_q <= right_sat;
  end

  ////////////////////////////////////////////////////////////
  // stage 3: master gain
  ////////////////////////////////////////////////////////////

  nq_multiplier #(
    .N_BITS (AUDIO_WIDTH),
    .Q_BITS (Q_BITS)
  ) left_mul (
    .clk          (clk),
    .rst_n        (rst_n),
    .multiplicand (left_sum_q),
    .multiplier   (output_gain),
    .product      (left_out),
    .overflow     (left_master_ovf)
  );

  nq_multiplier #(
    .N_BITS (AUDIO_WIDTH),
    .Q_BITS (Q_BITS)
  ) right_mul (
    .clk          (clk),
    .rst_n        (rst_n),
    .multiplicand (right_sum_q),
    .multiplier   (output_gain),
    .product      (right_out),
    .overflow     (right_master_ovf)
  );

  // valid and flag alignment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_d      <= '0;
      bus_clip_q   <= 1'b0;
      bus_clip_d   <= 1'b0;
      chan_clip_d1 <= '0;
      chan_clip_d2 <= '0;
    end else begin
      valid_d      <= {valid_d[1:0], frame_valid};
      bus_clip_q   <= left_bus_clip || right_bus_clip;  // stage 2
      bus_clip_d   <= bus_clip_q;                       // stage 3
      chan_clip_d1 <= chan_ovf;
      chan_clip_d2 <= chan_clip_d1;
    end
  end

  assign result.left         = left_out;
  assign result.right        = right_out;
  assign result.valid        = valid_d[2];
  assign result.out_clip     = bus_clip_d || left_master_ovf || right_master_ovf;
  assign result.channel_clip = chan_clip_d2;

endmodule

// ==== verilog/mixer_output.sv ====
////////////////////////////////////////////////////////////
// mixer_output: result holding register, valid/ready
// handshake, sticky clip and overrun status
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mixer_output (
  input  logic                  clk,
  input  logic                  rst_n,

  mix_result_if.sink            result,

  input  logic                  out_ready,
  input  logic                  status_clear,

  output mixer_pkg::sample_t    out_left,
  output mixer_pkg::sample_t    out_right,
  output logic                  out_valid,

  output logic                  out_clip,
  output mixer_pkg::chan_mask_t channel_clip,
  output logic                  overrun
);

  import mixer_pkg::*;

  logic full;
  logic drain;
  logic load;
  logic drop;

  assign drain = full && out_ready;             // transfer this edge
  assign load  = result.valid && (!full || drain);
  assign drop  = result.valid && full && !drain;  // core cannot stall

  assign out_valid = full;

  ////////////////////////////////////////////////////////////
  // holding register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      out_left  <= result.left;
      out_right <= result.right;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (drain) begin
      full <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // sticky status
  ////////////////////////////////////////////////////////////

  // a new flag in the clear cycle survives
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_clip     <= 1'b0;
      channel_clip <= '0;
      overrun      <= 1'b0;
    end else begin
      out_clip     <= (out_clip && !status_clear) || (result.valid && result.out_clip);
      channel_clip <= (channel_clip & {NR_CHANNELS{!status_clear}}) |
                      (result.channel_clip & {NR_CHANNELS{result.valid}});
      overrun      <= (overrun && !status_clear) || drop;
    end
  end

endmodule

// ==== verilog/mixer_pkg.sv ====
////////////////////////////////////////////////////////////
// mixer_pkg: audio and gain widths, channel count and the
// sample, gain, mask and frame types shared by the mixer
////////////////////////////////////////////////////////////

package mixer_pkg;

  ////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////

  localparam int AUDIO_WIDTH    = 16;
  localparam int GAIN_WIDTH     = 16;
  localparam int Q_BITS         = 12;  // 4096 is unity gain
  localparam int NR_CHANNELS    = 4;
  localparam int CHAN_IDX_WIDTH = 2;

  // room for every channel plus a sign guard
  localparam int SUM_WIDTH = AUDIO_WIDTH + CHAN_IDX_WIDTH + 1;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic signed [AUDIO_WIDTH-1:0] sample_t;
  typedef logic signed [GAIN_WIDTH-1:0]  gain_t;
  typedef logic [CHAN_IDX_WIDTH-1:0]     chan_idx_t;

  // pan select and per-channel clip bits
  typedef logic [NR_CHANNELS-1:0] chan_mask_t;

  typedef sample_t [NR_CHANNELS-1:0] frame_t;
  typedef gain_t   [NR_CHANNELS-1:0] gain_array_t;

endpackage

// ==== verilog/mixer_top.sv ====
////////////////////////////////////////////////////////////
// mixer_top: capture, mixer core and output stage
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mixer_top (
  input  logic                                                   clk,
  input  logic                                                   rst_n,

  // sample input
  input  logic signed [mixer_pkg::AUDIO_WIDTH-1:0]               sample,
  input  logic [mixer_pkg::CHAN_IDX_WIDTH-1:0]                   sample_chan,
  input  logic                                                   sample_strobe,

  // mix controls
  input  logic [mixer_pkg::NR_CHANNELS-1:0][mixer_pkg::GAIN_WIDTH-1:0] channel_gain,
  input  logic [mixer_pkg::NR_CHANNELS-1:0]                      channel_pan,
  input  logic signed [mixer_pkg::GAIN_WIDTH-1:0]                output_gain,
  input  logic                                                   status_clear,

  // stereo output
  output logic signed [mixer_pkg::AUDIO_WIDTH-1:0]               out_left,
  output logic signed [mixer_pkg::AUDIO_WIDTH-1:0]               out_right,
  output logic                                                   out_valid,
  input  logic                                                   out_ready,

  // sticky status
  output logic                                                   out_clip,
  output logic [mixer_pkg::NR_CHANNELS-1:0]                      channel_clip,
  output logic                                                   overrun
);

  import mixer_pkg::*;

  frame_t frame;
  logic   frame_valid;

  mix_result_if result_if ();

  channel_capture capture0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample        (sample),
    .sample_chan   (sample_chan),
    .sample_strobe (sample_strobe),
    .frame         (frame),
    .frame_valid   (frame_valid)
  );

  mixer_core core0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame        (frame),
    .frame_valid  (frame_valid),
    .channel_gain (channel_gain),
    .channel_pan  (channel_pan),
    .output_gain  (output_gain),
    .result       (result_if.core)
  );

  mixer_output output0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .result       (result_if.sink),
    .out_ready    (out_ready),
    .status_clear (status_clear),
    .out_left     (out_left),
    .out_right    (out_right),
    .out_valid    (out_valid),
    .out_clip     (out_clip),
    .channel_clip (channel_clip),
    .overrun      (overrun)
  );

endmodule

// ==== verilog/nq_multiplier.sv ====
////////////////////////////////////////////////////////////
// registered signed fixed-point multiply with saturation
// and overflow flag
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module nq_multiplier #(
  parameter int N_BITS = 16,
  parameter int Q_BITS = 12
) (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic signed [N_BITS-1:0] multiplicand,
  input  mixer_pkg::gain_t         multiplier,

  output logic signed [N_BITS-1:0] product,
  output logic                     overflow
);

  import mixer_pkg::*;

  logic signed [N_BITS+GAIN_WIDTH-1:0] full_product;
  logic signed [N_BITS+GAIN_WIDTH-1:0] shifted;
  logic                                fits;
  logic signed [N_BITS-1:0]            product_d;

  ////////////////////////////////////////////////////////////
  // multiply, shift, saturate
  ////////////////////////////////////////////////////////////

  assign full_product = (N_BITS+GAIN_WIDTH)'(multiplicand) * (N_BITS+GAIN_WIDTH)'(multiplier);
  assign shifted      = full_product >>> Q_BITS;  // floor toward minus infinity

  // upper bits must all match the result sign bit
  assign fits = (&shifted[N_BITS+GAIN_WIDTH-1:N_BITS-1]) ||
                !(|shifted[N_BITS+GAIN_WIDTH-1:N_BITS-1]);

  always_comb begin
    if (fits) begin
      product_d = shifted[N_BITS-1:0];
    end else if (shifted[N_BITS+GAIN_WIDTH-1]) begin
      product_d = {1'b1, {(N_BITS-1){1'b0}}};  // most negative
    end else begin
      product_d = {1'b0, {(N_BITS-1){1'b1}}};  // most positive
    end
  end

  ////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    product <= product_d;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else begin
      overflow <= !fits;
    end
  end

endmodule
